/* soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // timer region, matched on the address bits above the span
  localparam int CLINT_SPAN_BITS = 16;

  typedef logic [CLINT_SPAN_BITS-1:0] clint_off_t;

  localparam clint_off_t MTIMECMP_OFFSET = 16'h4000;
  localparam clint_off_t MTIME_OFFSET    = 16'hBFF8;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_DONE
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP,
    WR_DONE
  } wr_state_e;

endpackage

`default_nettype wire

/* clint_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_regs
  import soc_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_0000
) (
  input  wire logic  clock,
  input  wire logic  reset,
  input  wire addr_t rd_addr_i,
  input  wire addr_t wr_addr_i,
  input  wire logic  we_i,
  input  wire data_t wr_data_i,
  input  wire strb_t wr_strb_i,
  output logic       rd_hit_o,
  output logic       wr_hit_o,
  output data_t      rd_data_o,
  output logic       timer_irq_o
);

  localparam int ADDR_W = $bits(addr_t);
  localparam logic [ADDR_W-CLINT_SPAN_BITS-1:0] BASE_TAG = CLINT_BASE[ADDR_W-1:CLINT_SPAN_BITS];

  clint_off_t rd_off;
  clint_off_t wr_off;
  logic       mtime_we;
  logic       cmp_we;
  data_t      mtime;
  data_t      mtimecmp;

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // region decode
  assign rd_hit_o = (rd_addr_i[ADDR_W-1:CLINT_SPAN_BITS] == BASE_TAG);
  assign wr_hit_o = (wr_addr_i[ADDR_W-1:CLINT_SPAN_BITS] == BASE_TAG);
  assign rd_off   = rd_addr_i[CLINT_SPAN_BITS-1:0];
  assign wr_off   = wr_addr_i[CLINT_SPAN_BITS-1:0];

  always_comb begin
    case (rd_off)
      MTIME_OFFSET:    rd_data_o = mtime;
      MTIMECMP_OFFSET: rd_data_o = mtimecmp;
      default:         rd_data_o = '0;
    endcase
  end

  assign mtime_we = we_i && wr_hit_o && (wr_off == MTIME_OFFSET);
  assign cmp_we   = we_i && wr_hit_o && (wr_off == MTIMECMP_OFFSET);

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime       <= '0;
      mtimecmp    <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      // a write replaces the tick for that cycle
      if (mtime_we) begin
        mtime <= merge_bytes(mtime, wr_data_i, wr_strb_i);
      end else begin
        mtime <= mtime + data_t'(1);
      end
      if (cmp_we) begin
        mtimecmp <= merge_bytes(mtimecmp, wr_data_i, wr_strb_i);
      end
      timer_irq_o <= (mtime >= mtimecmp);
    end
  end

endmodule

`default_nettype wire

/* read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_arbiter
  import soc_bus_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  reset,

  input  wire logic  if_valid_i,
  input  wire addr_t if_addr_i,
  output logic       if_ready_o,
  output data_t      if_data_o,
  output resp_t      if_resp_o,

  input  wire logic  dr_valid_i,
  input  wire addr_t dr_addr_i,
  output logic       dr_ready_o,
  output data_t      dr_data_o,
  output resp_t      dr_resp_o,

  input  wire logic  clint_hit_i,
  input  wire data_t clint_data_i,

  output logic       ar_valid_o,
  input  wire logic  ar_ready_i,
  output addr_t      ar_addr_o,
  input  wire logic  r_valid_i,
  output logic       r_ready_o,
  input  wire data_t r_data_i,
  input  wire resp_t r_resp_i
);

  rd_state_e state;
  // set when the data-read port owns the current transfer
  logic      owner_dr;
  addr_t     addr_q;
  data_t     rsp_data;
  resp_t     rsp_resp;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= RD_IDLE;
      owner_dr <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          // data reads win over fetches
          if (dr_valid_i) begin
            owner_dr <= 1'b1;
            if (clint_hit_i) begin
              state <= RD_DONE;
            end else begin
              state <= RD_ADDR;
            end
          end else if (if_valid_i) begin
            owner_dr <= 1'b0;
            state    <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (ar_ready_i) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_valid_i) begin
            state <= RD_DONE;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // payload capture, timer data is taken at acceptance
  always_ff @(posedge clock) begin
    if (state == RD_IDLE) begin
      addr_q   <= dr_valid_i ? dr_addr_i : if_addr_i;
      rsp_data <= clint_data_i;
      rsp_resp <= RESP_OKAY;
    end else if (state == RD_DATA && r_valid_i) begin
      rsp_data <= r_data_i;
      rsp_resp <= r_resp_i;
    end
  end

  assign ar_valid_o = (state == RD_ADDR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state == RD_DATA);

  // one completion pulse, routed to the owner
  assign dr_ready_o = (state == RD_DONE) && owner_dr;
  assign if_ready_o = (state == RD_DONE) && !owner_dr;
  assign dr_data_o  = rsp_data;
  assign if_data_o  = rsp_data;
  assign dr_resp_o  = rsp_resp;
  assign if_resp_o  = rsp_resp;

endmodule

`default_nettype wire

/* store_port.sv */
`timescale 1ns/1ps
`default_nettype none

module store_port
  import soc_bus_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  reset,

  input  wire logic  dw_valid_i,
  input  wire addr_t dw_addr_i,
  input  wire data_t dw_data_i,
  input  wire strb_t dw_strb_i,
  output logic       dw_done_o,
  output resp_t      dw_resp_o,

  input  wire logic  clint_hit_i,
  output logic       clint_we_o,

  output logic       aw_valid_o,
  input  wire logic  aw_ready_i,
  output addr_t      aw_addr_o,
  output logic       w_valid_o,
  input  wire logic  w_ready_i,
  output data_t      w_data_o,
  output strb_t      w_strb_o,
  input  wire logic  b_valid_i,
  output logic       b_ready_o,
  input  wire resp_t b_resp_i
);

  wr_state_e state;
  logic      local_q;
  // address and data beats still owed to the bus
  logic      aw_pend;
  logic      w_pend;
  addr_t     addr_q;
  data_t     data_q;
  strb_t     strb_q;
  resp_t     resp_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= WR_IDLE;
      local_q <= 1'b0;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (dw_valid_i) begin
            local_q <= clint_hit_i;
            if (clint_hit_i) begin
              state <= WR_DONE;
            end else begin
              aw_pend <= 1'b1;
              w_pend  <= 1'b1;
              state   <= WR_SEND;
            end
          end
        end
        WR_SEND: begin
          if (aw_ready_i) begin
            aw_pend <= 1'b0;
          end
          if (w_ready_i) begin
            w_pend <= 1'b0;
          end
          if ((!aw_pend || aw_ready_i) && (!w_pend || w_ready_i)) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_valid_i) begin
            state <= WR_DONE;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == WR_IDLE) begin
      addr_q <= dw_addr_i;
      data_q <= dw_data_i;
      strb_q <= dw_strb_i;
      resp_q <= RESP_OKAY;
    end else if (state == WR_RESP && b_valid_i) begin
      resp_q <= b_resp_i;
    end
  end

  assign aw_valid_o = aw_pend;
  assign aw_addr_o  = addr_q;
  assign w_valid_o  = w_pend;
  assign w_data_o   = data_q;
  assign w_strb_o   = strb_q;
  assign b_ready_o  = (state == WR_RESP);

  // timer write lands in the same cycle as the completion pulse
  assign clint_we_o = (state == WR_DONE) && local_q;
  assign dw_done_o  = (state == WR_DONE);
  assign dw_resp_o  = resp_q;

endmodule

`default_nettype wire

/* core_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bus_top
  import soc_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_0000
) (
  input  wire logic  clock,
  input  wire logic  reset,

  // fetch port
  input  wire logic  if_valid_i,
  input  wire addr_t if_addr_i,
  output logic       if_ready_o,
  output data_t      if_data_o,
  output resp_t      if_resp_o,

  // data read port
  input  wire logic  dr_valid_i,
  input  wire addr_t dr_addr_i,
  output logic       dr_ready_o,
  output data_t      dr_data_o,
  output resp_t      dr_resp_o,

  // store port
  input  wire logic  dw_valid_i,
  input  wire addr_t dw_addr_i,
  input  wire data_t dw_data_i,
  input  wire strb_t dw_strb_i,
  output logic       dw_done_o,
  output resp_t      dw_resp_o,

  // axi read
  output logic       ar_valid_o,
  input  wire logic  ar_ready_i,
  output addr_t      ar_addr_o,
  input  wire logic  r_valid_i,
  output logic       r_ready_o,
  input  wire data_t r_data_i,
  input  wire resp_t r_resp_i,

  // axi write
  output logic       aw_valid_o,
  input  wire logic  aw_ready_i,
  output addr_t      aw_addr_o,
  output logic       w_valid_o,
  input  wire logic  w_ready_i,
  output data_t      w_data_o,
  output strb_t      w_strb_o,
  input  wire logic  b_valid_i,
  output logic       b_ready_o,
  input  wire resp_t b_resp_i,

  output logic       timer_irq_o
);

  logic  rd_hit;
  logic  wr_hit;
  logic  clint_we;
  data_t rd_data;

  read_arbiter u_read_arbiter (
    .clock        (clock),
    .reset        (reset),
    .if_valid_i   (if_valid_i),
    .if_addr_i    (if_addr_i),
    .if_ready_o   (if_ready_o),
    .if_data_o    (if_data_o),
    .if_resp_o    (if_resp_o),
    .dr_valid_i   (dr_valid_i),
    .dr_addr_i    (dr_addr_i),
    .dr_ready_o   (dr_ready_o),
    .dr_data_o    (dr_data_o),
    .dr_resp_o    (dr_resp_o),
    .clint_hit_i  (rd_hit),
    .clint_data_i (rd_data),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i)
  );

  store_port u_store_port (
    .clock       (clock),
    .reset       (reset),
    .dw_valid_i  (dw_valid_i),
    .dw_addr_i   (dw_addr_i),
    .dw_data_i   (dw_data_i),
    .dw_strb_i   (dw_strb_i),
    .dw_done_o   (dw_done_o),
    .dw_resp_o   (dw_resp_o),
    .clint_hit_i (wr_hit),
    .clint_we_o  (clint_we),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_addr_o   (aw_addr_o),
    .w_valid_o   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .w_data_o    (w_data_o),
    .w_strb_o    (w_strb_o),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .b_resp_i    (b_resp_i)
  );

  // timer block sees the core addresses directly
  clint_regs #(
    .CLINT_BASE (CLINT_BASE)
  ) u_clint_regs (
    .clock       (clock),
    .reset       (reset),
    .rd_addr_i   (dr_addr_i),
    .wr_addr_i   (dw_addr_i),
    .we_i        (clint_we),
    .wr_data_i   (dw_data_i),
    .wr_strb_i   (dw_strb_i),
    .rd_hit_o    (rd_hit),
    .wr_hit_o    (wr_hit),
    .rd_data_o   (rd_data),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

/* bus_props.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_props
  import soc_bus_pkg::*;
(
  input wire logic  clock,
  input wire logic  reset,
  input wire logic  ar_valid_o,
  input wire logic  ar_ready_i,
  input wire addr_t ar_addr_o,
  input wire logic  aw_valid_o,
  input wire logic  aw_ready_i,
  input wire addr_t aw_addr_o,
  input wire logic  w_valid_o,
  input wire logic  w_ready_i,
  input wire data_t w_data_o,
  input wire strb_t w_strb_o,
  input wire logic  if_valid_i,
  input wire logic  if_ready_o,
  input wire logic  dr_valid_i,
  input wire logic  dr_ready_o,
  input wire logic  dw_done_o,
  input wire logic  dw_valid_i
);

  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("AR valid or address changed before ready");

  a_aw_hold: assert property (@(posedge clock) disable iff (reset)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
    else $error("AW valid or address changed before ready");

  a_w_hold: assert property (@(posedge clock) disable iff (reset)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o))
    else $error("W valid or payload changed before ready");

  a_one_read_done: assert property (@(posedge clock) disable iff (reset)
    (if_ready_o || dr_ready_o) |-> (if_ready_o ? if_valid_i && !dr_ready_o : dr_valid_i))
    else $error("read completion on both ports or without a pending request");

  a_store_done: assert property (@(posedge clock) disable iff (reset)
    dw_done_o |-> dw_valid_i)
    else $error("store completion without a pending store");

endmodule

bind core_bus_top bus_props props (.*);

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import soc_bus_pkg::*;
#(
  parameter addr_t CLINT_BASE = 32'h0200_0000
) (
  input  wire logic  clock,
  input  wire logic  reset,
  input  wire logic  if_valid_i,
  input  wire addr_t if_addr_i,
  input  wire logic  if_ready_o,
  input  wire data_t if_data_o,
  input  wire resp_t if_resp_o,
  input  wire logic  dr_valid_i,
  input  wire addr_t dr_addr_i,
  input  wire logic  dr_ready_o,
  input  wire data_t dr_data_o,
  input  wire resp_t dr_resp_o,
  input  wire logic  dw_valid_i,
  input  wire addr_t dw_addr_i,
  input  wire data_t dw_data_i,
  input  wire strb_t dw_strb_i,
  input  wire logic  dw_done_o,
  input  wire resp_t dw_resp_o,
  input  wire logic  ar_valid_o,
  input  wire logic  ar_ready_i,
  input  wire addr_t ar_addr_o,
  input  wire logic  aw_valid_o,
  input  wire logic  aw_ready_i,
  input  wire addr_t aw_addr_o,
  input  wire logic  w_valid_o,
  input  wire logic  r_ready_o,
  input  wire logic  b_ready_o,
  input  wire logic  timer_irq_o,
  output int         completions_o,
  output int         err_count_o
);

  data_t  mem [addr_t];
  data_t  cmp_model;
  data_t  mtime_w;
  longint cycle;
  longint mtime_cycle;
  longint cmp_cycle;
  logic   seen_req;

  // initial memory content follows the same rule as the slave
  function automatic data_t fill_word(addr_t a);
    return {a ^ 32'hA5A5_0F0F, ~a + 32'd1};
  endfunction

  function automatic data_t mem_word(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic data_t merge(data_t old_v, data_t new_v, strb_t s);
    data_t r;
    r = old_v;
    for (int i = 0; i < 8; i++) begin
      if (s[i]) begin
        r[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic in_timer(addr_t a);
    return a[31:CLINT_SPAN_BITS] == CLINT_BASE[31:CLINT_SPAN_BITS];
  endfunction

  task automatic fail(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_count_o++;
  endtask

  task automatic check_read(input string port, input addr_t a, input data_t d, input resp_t r);
    data_t  exp;
    longint span;
    if (r != RESP_OKAY) begin
      fail($sformatf("%s read 0x%08h response %0d", port, a, r));
    end
    if (port == "data" && in_timer(a) && a[15:0] == MTIME_OFFSET) begin
      // mtime keeps running, so only a window is known
      span = cycle - mtime_cycle;
      if (d < mtime_w + data_t'(1) || d > mtime_w + data_t'(span)) begin
        fail($sformatf("mtime read %0d outside [%0d, %0d]", d, mtime_w + 1, mtime_w + span));
      end
    end else begin
      if (port == "data" && in_timer(a)) begin
        exp = (a[15:0] == MTIMECMP_OFFSET) ? cmp_model : '0;
      end else begin
        exp = mem_word(a);
      end
      if (d !== exp) begin
        fail($sformatf("%s read 0x%08h got %016h expected %016h", port, a, d, exp));
      end
    end
  endtask

  initial begin
    completions_o = 0;
    err_count_o   = 0;
  end

  always @(posedge clock) begin
    if (reset) begin
      cycle       = 0;
      mtime_w     = '0;
      mtime_cycle = 0;
      cmp_model   = '1;
      cmp_cycle   = 0;
      seen_req    = 1'b0;
    end else begin
      cycle++;
      if (!seen_req) begin
        if (if_ready_o || dr_ready_o || dw_done_o || ar_valid_o || aw_valid_o ||
            w_valid_o || r_ready_o || b_ready_o || timer_irq_o) begin
          fail("control output high before the first request");
        end
        seen_req = if_valid_i || dr_valid_i || dw_valid_i;
      end
      if (ar_valid_o && ar_ready_i && in_timer(ar_addr_o)) begin
        fail($sformatf("timer address 0x%08h sent on AR", ar_addr_o));
      end
      if (aw_valid_o && aw_ready_i && in_timer(aw_addr_o)) begin
        fail($sformatf("timer address 0x%08h sent on AW", aw_addr_o));
      end
      if (if_ready_o) begin
        completions_o++;
        check_read("fetch", if_addr_i, if_data_o, if_resp_o);
      end
      if (dr_ready_o) begin
        completions_o++;
        check_read("data", dr_addr_i, dr_data_o, dr_resp_o);
      end
      if (dw_done_o) begin
        completions_o++;
        if (dw_resp_o != RESP_OKAY) begin
          fail($sformatf("store 0x%08h response %0d", dw_addr_i, dw_resp_o));
        end
        if (!in_timer(dw_addr_i)) begin
          mem[dw_addr_i] = merge(mem_word(dw_addr_i), dw_data_i, dw_strb_i);
        end else if (dw_addr_i[15:0] == MTIME_OFFSET) begin
          mtime_w     = merge(mtime_w, dw_data_i, dw_strb_i);
          mtime_cycle = cycle;
        end else if (dw_addr_i[15:0] == MTIMECMP_OFFSET) begin
          cmp_model = merge(cmp_model, dw_data_i, dw_strb_i);
          cmp_cycle = cycle;
        end
      end
      // compare at all ones can never be reached by mtime here
      if (timer_irq_o && cmp_model == '1 && cycle > cmp_cycle + 2) begin
        fail("timer interrupt high with mtimecmp at all ones");
      end
    end
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import soc_bus_pkg::*;
;

  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t BUS_BASE   = 32'h8000_0000;
  localparam int    WAIT_LIMIT = 200;
  localparam logic [31:0] SEED = 32'h6519efab;

  logic  clock;
  logic  reset;
  logic  if_valid_i, if_ready_o;
  addr_t if_addr_i;
  data_t if_data_o;
  resp_t if_resp_o;
  logic  dr_valid_i, dr_ready_o;
  addr_t dr_addr_i;
  data_t dr_data_o;
  resp_t dr_resp_o;
  logic  dw_valid_i, dw_done_o;
  addr_t dw_addr_i;
  data_t dw_data_i;
  strb_t dw_strb_i;
  resp_t dw_resp_o;
  logic  ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
  addr_t ar_addr_o;
  data_t r_data_i;
  resp_t r_resp_i;
  logic  aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
  addr_t aw_addr_o;
  data_t w_data_o;
  strb_t w_strb_o;
  resp_t b_resp_i;
  logic  timer_irq_o;

  int          completions;
  int          chk_errors;
  int          tb_errors;
  int          issued;
  time         if_done_t;
  time         dr_done_t;
  logic [31:0] rnd_state [4];

  // slave side state
  data_t mem [addr_t];
  logic  rd_pend, aw_got, w_got;
  addr_t rd_addr, aw_a;
  data_t w_d;
  strb_t w_s;

  core_bus_top DUT (.*);

  tb_checker #(.CLINT_BASE(CLINT_BASE)) chk (
    .*,
    .completions_o (completions),
    .err_count_o   (chk_errors)
  );

  always #5 clock = ~clock;

  // streams 0 to 3 serve fetch, data read, store and slave
  function automatic logic [31:0] next_rand(input int idx);
    rnd_state[idx] = rnd_state[idx] * 32'd1664525 + 32'd1013904223;
    return rnd_state[idx];
  endfunction

  function automatic data_t fill_word(addr_t a);
    return {a ^ 32'hA5A5_0F0F, ~a + 32'd1};
  endfunction

  function automatic data_t slave_read(addr_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  always @(posedge clock) begin
    logic [31:0] r;
    data_t       old;
    if (reset) begin
      ar_ready_i <= 1'b0;
      r_valid_i  <= 1'b0;
      aw_ready_i <= 1'b0;
      w_ready_i  <= 1'b0;
      b_valid_i  <= 1'b0;
      rd_pend    <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
    end else begin
      r = next_rand(3);
      ar_ready_i <= r[31];
      aw_ready_i <= r[30];
      w_ready_i  <= r[29];
      if (ar_valid_o && ar_ready_i) begin
        rd_pend <= 1'b1;
        rd_addr <= ar_addr_o;
      end
      if (rd_pend && !r_valid_i && r[28]) begin
        r_valid_i <= 1'b1;
        r_data_i  <= slave_read(rd_addr);
        rd_pend   <= 1'b0;
      end
      if (r_valid_i && r_ready_o) begin
        r_valid_i <= 1'b0;
      end
      if (aw_valid_o && aw_ready_i) begin
        aw_got <= 1'b1;
        aw_a   <= aw_addr_o;
      end
      if (w_valid_o && w_ready_i) begin
        w_got <= 1'b1;
        w_d   <= w_data_o;
        w_s   <= w_strb_o;
      end
      if (aw_got && w_got && !b_valid_i && r[27]) begin
        old = slave_read(aw_a);
        for (int i = 0; i < 8; i++) begin
          if (w_s[i]) begin
            old[8*i +: 8] = w_d[8*i +: 8];
          end
        end
        mem[aw_a] = old;
        b_valid_i <= 1'b1;
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
      end
      if (b_valid_i && b_ready_o) begin
        b_valid_i <= 1'b0;
      end
    end
  end

  task automatic fetch_req(input addr_t a);
    int n;
    @(posedge clock);
    if_valid_i <= 1'b1;
    if_addr_i  <= a;
    issued++;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (!if_ready_o && n < WAIT_LIMIT);
    if (!if_ready_o) begin
      $display("timeout: fetch of 0x%08h never completed", a);
      tb_errors++;
    end
    if_done_t = $time;
    if_valid_i <= 1'b0;
  endtask

  task automatic dread_req(input addr_t a);
    int n;
    @(posedge clock);
    dr_valid_i <= 1'b1;
    dr_addr_i  <= a;
    issued++;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (!dr_ready_o && n < WAIT_LIMIT);
    if (!dr_ready_o) begin
      $display("timeout: data read of 0x%08h never completed", a);
      tb_errors++;
    end
    dr_done_t = $time;
    dr_valid_i <= 1'b0;
  endtask

  task automatic store_req(input addr_t a, input data_t d, input strb_t s);
    int n;
    @(posedge clock);
    dw_valid_i <= 1'b1;
    dw_addr_i  <= a;
    dw_data_i  <= d;
    dw_strb_i  <= s;
    issued++;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (!dw_done_o && n < WAIT_LIMIT);
    if (!dw_done_o) begin
      $display("timeout: store to 0x%08h never completed", a);
      tb_errors++;
    end
    dw_valid_i <= 1'b0;
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (timer_irq_o !== level && n < 20) begin
      @(posedge clock);
      n++;
    end
    if (timer_irq_o !== level) begin
      $display("timer interrupt did not reach level %0b within 20 cycles", level);
      tb_errors++;
    end
  endtask

  // reads use words 0..7 while random stores use words 8..15
  task automatic fetch_loop(input int count);
    logic [31:0] r;
    repeat (count) begin
      r = next_rand(0);
      fetch_req(BUS_BASE + addr_t'({r[18:16], 3'b000}));
    end
  endtask

  task automatic dread_loop(input int count);
    logic [31:0] r;
    repeat (count) begin
      r = next_rand(1);
      if (r[31:30] != 2'b00) begin
        dread_req(BUS_BASE + addr_t'({r[18:16], 3'b000}));
      end else if (r[29:28] == 2'b00) begin
        dread_req(CLINT_BASE | addr_t'(MTIME_OFFSET));
      end else if (r[29:28] == 2'b01) begin
        dread_req(CLINT_BASE | addr_t'(MTIMECMP_OFFSET));
      end else begin
        dread_req(CLINT_BASE | 32'h0010);
      end
    end
  endtask

  task automatic store_loop(input int count);
    logic [31:0] r;
    repeat (count) begin
      r = next_rand(2);
      store_req(BUS_BASE + 32'h40 + addr_t'({r[18:16], 3'b000}),
                {next_rand(2), next_rand(2)}, r[27:20]);
    end
  endtask

  initial begin
    addr_t a;
    rnd_state[0] = SEED;
    for (int i = 1; i < 4; i++) begin
      rnd_state[i] = rnd_state[i-1] * 32'd1664525 + 32'd1013904223;
    end
    clock = 1'b0;
    reset = 1'b1;
    if_valid_i = 1'b0;
    if_addr_i  = '0;
    dr_valid_i = 1'b0;
    dr_addr_i  = '0;
    dw_valid_i = 1'b0;
    dw_addr_i  = '0;
    dw_data_i  = '0;
    dw_strb_i  = '0;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i  = 1'b0;
    b_valid_i  = 1'b0;
    r_data_i   = '0;
    r_resp_i   = RESP_OKAY;
    b_resp_i   = RESP_OKAY;
    issued     = 0;
    tb_errors  = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    repeat (4) @(posedge clock);

    fork
      fetch_loop(40);
      dread_loop(40);
      store_loop(40);
    join

    // merged bytes read back on both ports
    for (int i = 0; i < 8; i++) begin
      a = BUS_BASE + 32'h40 + 32'(i * 8);
      store_req(a, {next_rand(2), next_rand(2)}, strb_t'(next_rand(2) >> 24));
      dread_req(a);
      fetch_req(a);
    end

    fork
      fetch_req(BUS_BASE + 32'h18);
      dread_req(BUS_BASE + 32'h28);
    join
    if (dr_done_t >= if_done_t) begin
      $display("CHECK FAILED at %0t: fetch completed before the same-cycle data read", $time);
      tb_errors++;
    end

    store_req(CLINT_BASE | addr_t'(MTIME_OFFSET), 64'h1000, 8'hFF);
    dread_req(CLINT_BASE | addr_t'(MTIME_OFFSET));
    dread_req(CLINT_BASE | 32'h0010);
    store_req(CLINT_BASE | addr_t'(MTIMECMP_OFFSET), 64'h20, 8'hFF);
    wait_irq(1'b1);
    store_req(CLINT_BASE | addr_t'(MTIMECMP_OFFSET), '1, 8'hFF);
    wait_irq(1'b0);
    dread_req(CLINT_BASE | addr_t'(MTIMECMP_OFFSET));
    repeat (3) @(posedge clock);

    if (completions != issued) begin
      $display("completion count %0d does not match %0d issued requests", completions, issued);
      tb_errors++;
    end
    $display("checker errors %0d, testbench errors %0d, requests %0d, completions %0d",
             chk_errors, tb_errors, issued, completions);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
soc_bus_pkg.sv
clint_regs.sv
read_arbiter.sv
store_port.sv
core_bus_top.sv
bus_props.sv
tb_checker.sv
tb_top.sv

/* Makefile */
SIM   ?= verilator
FLAGS ?= --binary --assert --timing
TOP   ?= tb_top
FLIST ?= src.f

OBJ  := obj_dir
BIN  := $(OBJ)/V$(TOP)
LOG  := sim.log
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
